/* source/mic_array_pkg.sv */
package mic_array_pkg;

	// array geometry
	parameter int NUM_MICS = 16;
	parameter int MIC_IDX_BITS = 4;

	// one I2S word per microphone per frame
	parameter int SAMPLE_BITS = 16;

	// DE2-115 SRAM is 1M x 16
	parameter int SRAM_ADDR_BITS = 20;

	// audio word tagged with the microphone it came from
	typedef struct packed {
		logic [MIC_IDX_BITS-1:0] mic;
		logic [SAMPLE_BITS-1:0] data;
	} mic_sample_t;

	// one SRAM write as seen on the pins
	typedef struct packed {
		logic [SRAM_ADDR_BITS-1:0] addr;
		logic [SAMPLE_BITS-1:0] data;
	} sram_write_t;

endpackage

/* source/mic_deserializer.sv */
`timescale 1ns/1ps

module mic_deserializer #(
	parameter int num_mics = mic_array_pkg::NUM_MICS
) (
	input  logic i_50m_clk,
	input  logic i_reset,
	input  logic i_bclk,
	input  logic i_lrck,
	input  logic [num_mics-1:0] i_mic_data,
	output logic [num_mics-1:0][mic_array_pkg::SAMPLE_BITS-1:0] o_frame,
	output logic o_frame_valid
);

	// slot 0 is the I2S delay bit, slots 1..SAMPLE_BITS carry data
	localparam int LAST_SLOT = mic_array_pkg::SAMPLE_BITS + 1;
	localparam int SLOT_BITS = $clog2(LAST_SLOT + 1);

	logic [2:0] bclk_sync;
	logic [2:0] lrck_sync;
	logic [num_mics-1:0] data_s1;
	logic [num_mics-1:0] data_s2;
	logic bclk_rise;
	logic lrck_fall;
	logic shift_en;
	logic [SLOT_BITS-1:0] slot_cnt;
	logic [num_mics-1:0][mic_array_pkg::SAMPLE_BITS-1:0] shift_q;

	// two flops into the 50 MHz domain, third one for edge detect
	always_ff @(posedge i_50m_clk) begin
		if (i_reset) begin
			bclk_sync <= '0;
			lrck_sync <= '0;
		end else begin
			bclk_sync <= {bclk_sync[1:0], i_bclk};
			lrck_sync <= {lrck_sync[1:0], i_lrck};
		end
	end

	// data lines get the same two-flop delay as the bit clock
	always_ff @(posedge i_50m_clk) begin
		data_s1 <= i_mic_data;
		data_s2 <= data_s1;
	end

	assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
	assign lrck_fall = ~lrck_sync[1] & lrck_sync[2];

	// only data slots shift, the delay slot and the tail are skipped
	assign shift_en = bclk_rise && (slot_cnt != '0) && (slot_cnt != SLOT_BITS'(LAST_SLOT));

	// slot counter restarts on every word clock fall and saturates
	always_ff @(posedge i_50m_clk) begin
		if (i_reset) begin
			slot_cnt <= SLOT_BITS'(LAST_SLOT);
		end else if (lrck_fall) begin
			slot_cnt <= '0;
		end else if (bclk_rise && slot_cnt != SLOT_BITS'(LAST_SLOT)) begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	// MSB first, so shift in from the bottom
	always_ff @(posedge i_50m_clk) begin
		if (shift_en) begin
			for (int m = 0; m < num_mics; m++) begin
				shift_q[m] <= {shift_q[m][mic_array_pkg::SAMPLE_BITS-2:0], data_s2[m]};
			end
		end
	end

	// hand over the finished words at the next fall
	always_ff @(posedge i_50m_clk) begin
		if (lrck_fall) begin
			o_frame <= shift_q;
		end
	end

	always_ff @(posedge i_50m_clk) begin
		if (i_reset) begin
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= lrck_fall;
		end
	end

endmodule

/* source/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int num_mics = mic_array_pkg::NUM_MICS
) (
	input  logic i_50m_clk,
	input  logic i_reset,
	input  logic [num_mics-1:0][mic_array_pkg::SAMPLE_BITS-1:0] i_frame,
	input  logic i_frame_valid,
	input  logic i_sample_ready,
	output mic_array_pkg::mic_sample_t o_sample,
	output logic o_sample_valid
);

	localparam logic [mic_array_pkg::MIC_IDX_BITS-1:0] LAST_IDX =
		mic_array_pkg::MIC_IDX_BITS'(num_mics - 1);

	logic [num_mics-1:0][mic_array_pkg::SAMPLE_BITS-1:0] frame_q;
	logic [mic_array_pkg::MIC_IDX_BITS-1:0] idx_q;
	logic take;

	assign take = o_sample_valid & i_sample_ready;

	// frame buffer, refilled once per word clock
	always_ff @(posedge i_50m_clk) begin
		if (i_frame_valid) begin
			frame_q <= i_frame;
		end
	end

	// step through the microphones, one per transfer
	always_ff @(posedge i_50m_clk) begin
		if (i_reset) begin
			o_sample_valid <= 1'b0;
			idx_q <= '0;
		end else if (i_frame_valid) begin
			o_sample_valid <= 1'b1;
			idx_q <= '0;
		end else if (take) begin
			if (idx_q == LAST_IDX) begin
				// last word gone, back to idle
				o_sample_valid <= 1'b0;
			end else begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	// current word tagged with its index
	always_comb begin
		o_sample.mic = idx_q;
		o_sample.data = frame_q[idx_q];
	end

endmodule

/* source/sram_recorder.sv */
`timescale 1ns/1ps

module sram_recorder #(
	parameter int record_words = 1 << mic_array_pkg::SRAM_ADDR_BITS
) (
	input  logic i_50m_clk,
	input  logic i_reset,
	input  logic i_start,
	input  mic_array_pkg::mic_sample_t i_sample,
	input  logic i_sample_valid,
	output logic o_sample_ready,
	output logic [mic_array_pkg::SRAM_ADDR_BITS-1:0] o_sram_addr,
	output logic [mic_array_pkg::SAMPLE_BITS-1:0] o_sram_dq,
	output logic o_sram_we_n,
	output logic o_sram_ce_n,
	output mic_array_pkg::sram_write_t o_write,
	output logic o_write_valid,
	output logic o_record_start,
	output logic o_recording,
	output logic o_done
);

	localparam logic [mic_array_pkg::SRAM_ADDR_BITS-1:0] LAST_ADDR =
		mic_array_pkg::SRAM_ADDR_BITS'(record_words - 1);

	// setup and strobe are the two cycles of one SRAM write
	typedef enum logic [2:0] {
		S_IDLE,
		S_ARMED,
		S_RECORD,
		S_SETUP,
		S_STROBE,
		S_DONE
	} state_t;

	state_t state_q;
	logic [mic_array_pkg::SRAM_ADDR_BITS-1:0] addr_q;
	logic [mic_array_pkg::SAMPLE_BITS-1:0] data_q;
	logic accept;
	logic first_take;

	// no new sample while a write is on the pins
	assign o_sample_ready = (state_q != S_SETUP) && (state_q != S_STROBE);
	assign accept = i_sample_valid & o_sample_ready;

	// recording starts on a frame boundary
	assign first_take = (state_q == S_ARMED) && accept && (i_sample.mic == '0);

	always_ff @(posedge i_50m_clk) begin
		if (i_reset) begin
			state_q <= S_IDLE;
			addr_q <= '0;
		end else begin
			case (state_q)
				S_IDLE, S_DONE: begin
					if (i_start) begin
						state_q <= S_ARMED;
						addr_q <= '0;
					end
				end
				S_ARMED: begin
					if (first_take) begin
						state_q <= S_SETUP;
					end
				end
				S_RECORD: begin
					if (accept) begin
						state_q <= S_SETUP;
					end
				end
				S_SETUP: begin
					state_q <= S_STROBE;
				end
				S_STROBE: begin
					if (addr_q == LAST_ADDR) begin
						state_q <= S_DONE;
					end else begin
						state_q <= S_RECORD;
						addr_q <= addr_q + 1'b1;
					end
				end
				default: begin
					state_q <= S_IDLE;
				end
			endcase
		end
	end

	// word held on the data pins through setup and strobe
	always_ff @(posedge i_50m_clk) begin
		if (accept) begin
			data_q <= i_sample.data;
		end
	end

	assign o_recording = (state_q == S_RECORD) || (state_q == S_SETUP) ||
		(state_q == S_STROBE);
	assign o_done = (state_q == S_DONE);
	assign o_record_start = first_take;

	// SRAM pins, active low strobes
	assign o_sram_addr = addr_q;
	assign o_sram_dq = data_q;
	assign o_sram_ce_n = ~o_recording;
	assign o_sram_we_n = (state_q != S_STROBE);

	// copy of the write for the level meter
	assign o_write.addr = addr_q;
	assign o_write.data = data_q;
	assign o_write_valid = (state_q == S_STROBE);

endmodule

/* source/peak_meter.sv */
`timescale 1ns/1ps

module peak_meter (
	input  logic i_50m_clk,
	input  logic i_reset,
	input  mic_array_pkg::sram_write_t i_write,
	input  logic i_write_valid,
	input  logic i_record_start,
	output logic [mic_array_pkg::SAMPLE_BITS-2:0] o_peak
);

	localparam int W = mic_array_pkg::SAMPLE_BITS;

	logic [W-1:0] negated;
	logic [W-2:0] magnitude;
	logic restart_pend;

	// |x| in W-1 bits, the most negative value clips to full scale
	always_comb begin
		negated = ~i_write.data + 1'b1;
		if (!i_write.data[W-1]) begin
			magnitude = i_write.data[W-2:0];
		end else if (negated[W-1]) begin
			magnitude = '1;
		end else begin
			magnitude = negated[W-2:0];
		end
	end

	// start pulse comes at acceptance, the write itself a few cycles later
	always_ff @(posedge i_50m_clk) begin
		if (i_reset) begin
			restart_pend <= 1'b0;
			o_peak <= '0;
		end else begin
			if (i_write_valid) begin
				if (restart_pend || magnitude > o_peak) begin
					o_peak <= magnitude;
				end
			end
			if (i_record_start) begin
				restart_pend <= 1'b1;
			end else if (i_write_valid) begin
				restart_pend <= 1'b0;
			end
		end
	end

endmodule

/* source/mic_array_recorder_top.sv */
`timescale 1ns/1ps

module mic_array_recorder_top #(
	parameter int num_mics = mic_array_pkg::NUM_MICS,
	parameter int record_words = 1 << mic_array_pkg::SRAM_ADDR_BITS
) (
	input  logic i_50m_clk,
	input  logic i_reset,
	input  logic i_start,
	input  logic i_bclk,
	input  logic i_lrck,
	input  logic [num_mics-1:0] i_mic_data,
	output logic [mic_array_pkg::SRAM_ADDR_BITS-1:0] o_sram_addr,
	output logic [mic_array_pkg::SAMPLE_BITS-1:0] o_sram_dq,
	output logic o_sram_we_n,
	output logic o_sram_ce_n,
	output logic o_recording,
	output logic o_done,
	output logic [mic_array_pkg::SAMPLE_BITS-2:0] o_peak
);

	logic [num_mics-1:0][mic_array_pkg::SAMPLE_BITS-1:0] frame;
	logic frame_valid;
	mic_array_pkg::mic_sample_t sample;
	logic sample_valid;
	logic sample_ready;
	mic_array_pkg::sram_write_t write;
	logic write_valid;
	logic record_start;

	// I2S lines to one parallel frame per word clock
	mic_deserializer #(
		.num_mics(num_mics)
	) deser_i (
		.i_50m_clk(i_50m_clk),
		.i_reset(i_reset),
		.i_bclk(i_bclk),
		.i_lrck(i_lrck),
		.i_mic_data(i_mic_data),
		.o_frame(frame),
		.o_frame_valid(frame_valid)
	);

	frame_sequencer #(
		.num_mics(num_mics)
	) seq_i (
		.i_50m_clk(i_50m_clk),
		.i_reset(i_reset),
		.i_frame(frame),
		.i_frame_valid(frame_valid),
		.i_sample_ready(sample_ready),
		.o_sample(sample),
		.o_sample_valid(sample_valid)
	);

	sram_recorder #(
		.record_words(record_words)
	) rec_i (
		.i_50m_clk(i_50m_clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.i_sample(sample),
		.i_sample_valid(sample_valid),
		.o_sample_ready(sample_ready),
		.o_sram_addr(o_sram_addr),
		.o_sram_dq(o_sram_dq),
		.o_sram_we_n(o_sram_we_n),
		.o_sram_ce_n(o_sram_ce_n),
		.o_write(write),
		.o_write_valid(write_valid),
		.o_record_start(record_start),
		.o_recording(o_recording),
		.o_done(o_done)
	);

	// level of the current take
	peak_meter peak_i (
		.i_50m_clk(i_50m_clk),
		.i_reset(i_reset),
		.i_write(write),
		.i_write_valid(write_valid),
		.i_record_start(record_start),
		.o_peak(o_peak)
	);

endmodule

/* testbench/mic_array_recorder_chk.sv */
`timescale 1ns/1ps

module mic_array_recorder_chk (
	input logic i_clk,
	input logic i_reset,
	input logic i_valid,
	input logic i_ready,
	input mic_array_pkg::mic_sample_t i_data,
	input logic i_frame_valid,
	input logic i_we_n,
	input logic i_ce_n
);

	int fail_count = 0;

	// stalled word stays put
	hold_until_taken: assert property (
		@(posedge i_clk) disable iff (i_reset)
		i_valid && !i_ready |=> i_valid && $stable(i_data)
	) else begin
		$error("sample valid dropped or data changed before ready");
		fail_count++;
	end

	// a frame drains long before the next word clock
	no_frame_overrun: assert property (
		@(posedge i_clk) disable iff (i_reset)
		i_frame_valid |-> !i_valid
	) else begin
		$error("new frame arrived while the sequencer was still busy");
		fail_count++;
	end

	strobe_needs_select: assert property (
		@(posedge i_clk) disable iff (i_reset)
		!i_we_n |-> !i_ce_n
	) else begin
		$error("SRAM we_n low while ce_n high");
		fail_count++;
	end

endmodule

bind frame_sequencer mic_array_recorder_chk seq_chk_i (
	.i_clk(i_50m_clk),
	.i_reset(i_reset),
	.i_valid(o_sample_valid),
	.i_ready(i_sample_ready),
	.i_data(o_sample),
	.i_frame_valid(i_frame_valid),
	.i_we_n(1'b1),
	.i_ce_n(1'b1)
);

bind sram_recorder mic_array_recorder_chk rec_chk_i (
	.i_clk(i_50m_clk),
	.i_reset(i_reset),
	.i_valid(1'b0),
	.i_ready(1'b1),
	.i_data('0),
	.i_frame_valid(1'b0),
	.i_we_n(o_sram_we_n),
	.i_ce_n(o_sram_ce_n)
);

/* testbench/tb_mic_array_recorder.sv */
`timescale 1ns/1ps

module tb_mic_array_recorder;

	localparam int NM = mic_array_pkg::NUM_MICS;
	localparam int W = mic_array_pkg::SAMPLE_BITS;
	localparam int RECORD_WORDS = 64;
	localparam int CLK_NS = 20;
	localparam int FRAME_CYCLES = 1024;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_NS = 12 * FRAME_CYCLES * CLK_NS * NUM_TESTS + 50_000;

	typedef logic [NM-1:0][W-1:0] frame_t;

	logic i_50m_clk;
	logic i_reset;
	logic i_start;
	logic i_bclk;
	logic i_lrck;
	logic [NM-1:0] i_mic_data;
	logic [mic_array_pkg::SRAM_ADDR_BITS-1:0] o_sram_addr;
	logic [W-1:0] o_sram_dq;
	logic o_sram_we_n;
	logic o_sram_ce_n;
	logic o_recording;
	logic o_done;
	logic [W-2:0] o_peak;

	// microphone model state with one entry per serialized frame
	frame_t frame_log[$];
	int frame_num;
	int bit_idx;
	int amp_shift = 0;
	logic [W-1:0] forced_words[int];

	logic [W-1:0] sram_mem[int];
	int write_count = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int assert_fails;

	mic_array_recorder_top #(
		.num_mics(NM),
		.record_words(RECORD_WORDS)
	) dut_i (
		.i_50m_clk(i_50m_clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.i_bclk(i_bclk),
		.i_lrck(i_lrck),
		.i_mic_data(i_mic_data),
		.o_sram_addr(o_sram_addr),
		.o_sram_dq(o_sram_dq),
		.o_sram_we_n(o_sram_we_n),
		.o_sram_ce_n(o_sram_ce_n),
		.o_recording(o_recording),
		.o_done(o_done),
		.o_peak(o_peak)
	);

	initial begin
		i_50m_clk = 1'b0;
		forever begin
			#(CLK_NS / 2) i_50m_clk = ~i_50m_clk;
		end
	end

	// asynchronous SRAM sampled mid-cycle
	always @(negedge i_50m_clk) begin
		if (!o_sram_we_n && !o_sram_ce_n) begin
			sram_mem[int'(o_sram_addr)] = o_sram_dq;
			write_count++;
			if (o_recording !== 1'b1) begin
				log_mismatch("o_recording low during an SRAM write");
			end
		end
	end

	// I2S array with 64 bit clocks per word clock and data changing while bclk is low
	initial begin
		frame_t words;
		logic [31:0] raw;
		logic signed [W-1:0] val;
		void'($urandom(32'h2233_59cd));
		frame_num = -1;
		bit_idx = 0;
		@(posedge i_50m_clk);
		#1;
		forever begin
			for (int m = 0; m < NM; m++) begin
				raw = $urandom;
				val = $signed(raw[W-1:0]) >>> amp_shift;
				words[m] = val;
				if (forced_words.exists((frame_num + 1) * NM + m)) begin
					words[m] = forced_words[(frame_num + 1) * NM + m];
				end
			end
			frame_log.push_back(words);
			frame_num++;
			for (int b = 0; b < 64; b++) begin
				bit_idx = b;
				i_bclk = 1'b0;
				i_lrck = (b >= 32);
				// slot 0 is the delay bit and then MSB first
				for (int m = 0; m < NM; m++) begin
					i_mic_data[m] = (b >= 1 && b <= W) ? words[m][W - b] : 1'b0;
				end
				repeat (8) @(posedge i_50m_clk);
				#1;
				i_bclk = 1'b1;
				repeat (8) @(posedge i_50m_clk);
				#1;
			end
		end
	end

	task automatic next_cycle(input int n);
		repeat (n) @(posedge i_50m_clk);
		#1;
	endtask

	task automatic log_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// |x| with -32768 clipped to full scale
	function automatic int expected_magnitude(input logic [W-1:0] word);
		int v;
		v = $signed(word);
		if (v < 0) begin
			v = -v;
		end
		if (v > 32767) begin
			v = 32767;
		end
		return v;
	endfunction

	function automatic int expected_peak(input int first);
		int peak;
		peak = 0;
		for (int a = 0; a < RECORD_WORDS; a++) begin
			if (expected_magnitude(frame_log[first + a / NM][a % NM]) > peak) begin
				peak = expected_magnitude(frame_log[first + a / NM][a % NM]);
			end
		end
		return peak;
	endfunction

	// start in the middle of a fresh frame, wait for done, compare the SRAM image
	task automatic record_take(input int force_mic, input logic [W-1:0] force_val,
		output int first);
		int frame_before;
		int count_before;
		int waited;
		logic [W-1:0] exp;
		frame_before = frame_num;
		// the second recorded frame has not been generated yet
		if (force_mic >= 0) begin
			forced_words[(frame_before + 2) * NM + force_mic] = force_val;
		end
		while (frame_num == frame_before || bit_idx != 24) begin
			next_cycle(1);
		end
		first = frame_num;
		count_before = write_count;
		i_start = 1'b1;
		next_cycle(1);
		i_start = 1'b0;
		waited = 0;
		while (!o_done && waited < 8 * FRAME_CYCLES) begin
			next_cycle(1);
			waited++;
		end
		if (!o_done) begin
			$display("ERROR: o_done did not rise within 8 frame periods after start");
			errors++;
		end
		next_cycle(2);
		if (write_count - count_before != RECORD_WORDS) begin
			log_mismatch($sformatf("%0d writes, expected %0d",
				write_count - count_before, RECORD_WORDS));
		end
		for (int a = 0; a < RECORD_WORDS; a++) begin
			exp = frame_log[first + a / NM][a % NM];
			if (!sram_mem.exists(a)) begin
				log_mismatch($sformatf("address %0d never written", a));
			end else if (sram_mem[a] !== exp) begin
				log_mismatch($sformatf("address %0d holds %h, expected %h",
					a, sram_mem[a], exp));
			end
		end
	endtask

	task automatic test_reset_state();
		int errors_before;
		errors_before = errors;
		// frames stream but nobody pressed start
		for (int c = 0; c < 3 * FRAME_CYCLES; c++) begin
			if (o_sram_we_n !== 1'b1 || o_sram_ce_n !== 1'b1 || o_recording !== 1'b0 ||
				o_done !== 1'b0 || o_peak !== '0) begin
				log_mismatch($sformatf("idle outputs we_n=%b ce_n=%b rec=%b done=%b peak=%0d",
					o_sram_we_n, o_sram_ce_n, o_recording, o_done, o_peak));
				break;
			end
			next_cycle(1);
		end
		if (write_count != 0) begin
			log_mismatch($sformatf("%0d SRAM writes without a start", write_count));
		end
		finish_test("reset_state", errors_before);
	endtask

	task automatic test_mid_frame_start();
		int errors_before;
		int first;
		errors_before = errors;
		record_take(-1, '0, first);
		finish_test("mid_frame_start", errors_before);
	endtask

	task automatic test_completion();
		int errors_before;
		int count_before;
		errors_before = errors;
		if (o_done !== 1'b1 || o_recording !== 1'b0 || o_sram_ce_n !== 1'b1) begin
			log_mismatch($sformatf("after last write done=%b rec=%b ce_n=%b",
				o_done, o_recording, o_sram_ce_n));
		end
		count_before = write_count;
		next_cycle(2 * FRAME_CYCLES);
		if (write_count != count_before) begin
			log_mismatch($sformatf("%0d writes after done", write_count - count_before));
		end
		if (o_done !== 1'b1) begin
			log_mismatch("o_done dropped without a new start");
		end
		finish_test("completion", errors_before);
	endtask

	task automatic test_peak_tracking();
		int errors_before;
		int first;
		errors_before = errors;
		record_take(5, 16'h8000, first);
		if (int'(o_peak) != 32767) begin
			log_mismatch($sformatf("peak %0d with -32768 recorded, expected 32767", o_peak));
		end
		// smaller samples, so the peak is a value below full scale
		amp_shift = 4;
		record_take(-1, '0, first);
		if (int'(o_peak) != expected_peak(first)) begin
			log_mismatch($sformatf("peak %0d, expected %0d", o_peak, expected_peak(first)));
		end
		finish_test("peak_tracking", errors_before);
	endtask

	task automatic test_restart();
		int errors_before;
		int first;
		errors_before = errors;
		amp_shift = 6;
		record_take(-1, '0, first);
		if (int'(o_peak) != expected_peak(first)) begin
			log_mismatch($sformatf("peak %0d after restart, expected %0d",
				o_peak, expected_peak(first)));
		end
		finish_test("restart", errors_before);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: simulation ran past %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		i_reset = 1'b1;
		i_start = 1'b0;
		i_bclk = 1'b0;
		i_lrck = 1'b1;
		i_mic_data = '0;
		next_cycle(2);
		i_reset = 1'b0;
		test_reset_state();
		test_mid_frame_start();
		test_completion();
		test_peak_tracking();
		test_restart();
		assert_fails = dut_i.seq_i.seq_chk_i.fail_count +
			dut_i.rec_i.rec_chk_i.fail_count;
		if (assert_fails != 0) begin
			$display("bound assertions failed %0d times", assert_fails);
			errors += assert_fails;
		end
		$display("tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* compile.f */
source/mic_array_pkg.sv
source/mic_deserializer.sv
source/frame_sequencer.sv
source/sram_recorder.sv
source/peak_meter.sv
source/mic_array_recorder_top.sv
testbench/mic_array_recorder_chk.sv
testbench/tb_mic_array_recorder.sv

/* Bender.yml */
package:
  name: mic_array_recorder

sources:
  - source/mic_array_pkg.sv
  - source/mic_deserializer.sv
  - source/frame_sequencer.sv
  - source/sram_recorder.sv
  - source/peak_meter.sv
  - source/mic_array_recorder_top.sv
  - target: test
    files:
      - testbench/mic_array_recorder_chk.sv
      - testbench/tb_mic_array_recorder.sv
